// File: sim.f
+incdir+tb
src/rv_pkg.sv
src/rv_regfile.sv
src/rv_fetch.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_retire.sv
src/rv_core.sv
tb/rv_core_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = rv_core_tb
FILELIST  = sim.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// File: tb/rv_core_tasks.svh
`ifndef RV_CORE_TASKS_SVH
`define RV_CORE_TASKS_SVH

localparam logic [6:0]  OPC_I      = 7'b0010011;
localparam logic [6:0]  OPC_LUI    = 7'b0110111;
localparam logic [6:0]  OPC_AUIPC  = 7'b0010111;
localparam logic [6:0]  OPC_BRANCH = 7'b1100011;
localparam logic [6:0]  OPC_JAL    = 7'b1101111;
localparam logic [6:0]  OPC_JALR   = 7'b1100111;
localparam logic [31:0] NOP_WORD   = 32'h0000_0013; // ADDI x0, x0, 0

function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    r_type = {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] opc);
    i_type = {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                       input logic [6:0] opc);
    u_type = {imm, rd, opc};
endfunction

function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    b_type = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
    j_type = {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
endfunction

// Two's complement order from the sign bits first
function automatic logic signed_less(input logic [31:0] x, input logic [31:0] y);
    if (x[31] != y[31]) begin
        signed_less = x[31];
    end else begin
        signed_less = (x < y);
    end
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] x,
                                      input logic [31:0] y);
    case (f3)
        3'b000:  branch_taken = (x == y);
        3'b001:  branch_taken = (x != y);
        3'b100:  branch_taken = signed_less(x, y);
        3'b101:  branch_taken = !signed_less(x, y);
        3'b110:  branch_taken = (x < y);
        default: branch_taken = !(x < y);
    endcase
endfunction

task automatic reset_dut();
    rst = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
endtask

task automatic new_program();
    prog.delete();
    for (int r = 0; r < 32; r++) begin
        exp_on[r]  = 1'b0;
        exp_val[r] = '0;
    end
endtask

task automatic put(input logic [31:0] w);
    prog.push_back(w);
endtask

// Two NOPs keep a following reader clear of the write
task automatic put_spaced(input logic [31:0] w);
    put(w);
    put(NOP_WORD);
    put(NOP_WORD);
endtask

task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = v + 32'h0000_0800; // ADDI sign-extends the low part
    put_spaced(u_type(hi[31:12], rd, OPC_LUI));
    put_spaced(i_type(v[11:0], rd, 3'b000, rd, OPC_I));
endtask

task automatic expect_reg(input logic [4:0] r, input logic [31:0] v);
    exp_on[r]  = 1'b1;
    exp_val[r] = v;
endtask

task automatic load_program();
    if (prog.size() > IMEM_DEPTH) begin
        errors++;
        $display("Program of %0d words does not fit in instruction memory", prog.size());
    end
    for (int i = 0; i < prog.size() && i < IMEM_DEPTH; i++) begin
        imem_we    = 1'b1;
        imem_addr  = IMEM_AW'(i);
        imem_wdata = prog[i];
        @(posedge clk);
        #1;
    end
    imem_we = 1'b0;
endtask

task automatic check_regs(input string name);
    for (int r = 0; r < 32; r++) begin
        if (exp_on[r]) begin
            dbg_addr = 5'(r);
            @(negedge clk);
            checks++;
            if (dbg_data !== exp_val[r]) begin
                errors++;
                $display("MISMATCH time=%0t test=%s signal=x%0d expected=0x%08h actual=0x%08h",
                         $time, name, r, exp_val[r], dbg_data);
            end
            @(posedge clk);
            #1;
        end
    end
endtask

task automatic run_program(input string name);
    int n_ctrl;
    int cycles;
    n_ctrl = 0;
    put(j_type(21'd0, 5'd0)); // Park on a self loop
    foreach (prog[i]) begin
        if (prog[i][6:0] inside {OPC_BRANCH, OPC_JAL, OPC_JALR}) begin
            n_ctrl++;
        end
    end
    cycles = 5 * prog.size() + 4 * n_ctrl;
    reset_dut();
    load_program();
    run = 1'b1;
    repeat (cycles) @(posedge clk);
    #1;
    run = 1'b0;
    repeat (6) @(posedge clk); // Drain stages behind fetch
    #1;
    check_regs(name);
endtask

`endif

// File: tb/rv_core_tb.sv
`default_nettype none

module rv_core_tb;

    localparam int CLK_PERIOD = 8;
    localparam int IMEM_DEPTH = 64;
    localparam int IMEM_AW    = $clog2(IMEM_DEPTH);
    localparam int NUM_TESTS  = 5;
    // Reset, full load, every slot a jump, drain, debug reads
    localparam int TEST_CYCLES     = 5 + IMEM_DEPTH + 9 * IMEM_DEPTH + 8 + 2 * 32;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * TEST_CYCLES + 200;

    logic               clk;
    logic               rst;
    logic               run;
    logic               imem_we;
    logic [IMEM_AW-1:0] imem_addr;
    logic [31:0]        imem_wdata;
    logic [4:0]         dbg_addr;
    logic [31:0]        dbg_data;

    logic [31:0] prog [$];
    logic [31:0] exp_val [32];
    logic        exp_on [32];
    int          errors;
    int          checks;

    `include "rv_core_tasks.svh"

    rv_core #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) i_rv_core (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .dbg_addr   (dbg_addr),
        .dbg_data   (dbg_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, tests did not complete", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    task automatic regs_clear_after_reset();
        new_program();
        reset_dut();
        for (int r = 0; r < 32; r++) begin
            expect_reg(5'(r), 32'd0);
        end
        check_regs("reset");
    endtask

    task automatic r_type_results();
        logic [31:0] a;
        logic [31:0] b;
        a = $urandom() | 32'h8000_0000; // Negative
        b = $urandom() & 32'h7fff_ffff;
        new_program();
        load_const(5'd1, a);
        load_const(5'd2, b);
        put(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd10)); // ADD
        put(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd11)); // SUB
        put(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd12));
        put(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd13));
        put(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd14));
        put(r_type(7'h00, 5'd2, 5'd1, 3'b001, 5'd15)); // SLL
        put(r_type(7'h00, 5'd2, 5'd1, 3'b101, 5'd16)); // SRL
        put(r_type(7'h20, 5'd2, 5'd1, 3'b101, 5'd17)); // SRA
        put(r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd18)); // SLT
        put(r_type(7'h00, 5'd2, 5'd1, 3'b011, 5'd19)); // SLTU
        put(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd20));
        put(r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd21));
        expect_reg(5'd1, a);
        expect_reg(5'd2, b);
        expect_reg(5'd10, a + b);
        expect_reg(5'd11, a - b);
        expect_reg(5'd12, a ^ b);
        expect_reg(5'd13, a | b);
        expect_reg(5'd14, a & b);
        expect_reg(5'd15, a << b[4:0]);
        expect_reg(5'd16, a >> b[4:0]);
        expect_reg(5'd17, (a >> b[4:0]) | ~(32'hffff_ffff >> b[4:0])); // Sign fill
        expect_reg(5'd18, {31'b0, signed_less(a, b)});
        expect_reg(5'd19, {31'b0, a < b});
        expect_reg(5'd20, {31'b0, signed_less(b, a)});
        expect_reg(5'd21, {31'b0, b < a});
        run_program("r_type");
    endtask

    task automatic i_type_results();
        logic [31:0] a;
        logic [31:0] b;
        logic [11:0] imm;
        logic [31:0] sx;
        logic [4:0]  sh;
        logic [19:0] up;
        logic [31:0] auipc_pc;
        a   = $urandom() | 32'h8000_0000;
        b   = $urandom() & 32'h7fff_ffff;
        imm = 12'($urandom());
        sx  = {{20{imm[11]}}, imm};
        sh  = 5'($urandom());
        up  = 20'($urandom());
        new_program();
        load_const(5'd1, a);
        load_const(5'd2, b);
        put(i_type(imm, 5'd1, 3'b000, 5'd10, OPC_I)); // ADDI
        put(i_type(imm, 5'd1, 3'b100, 5'd11, OPC_I));
        put(i_type(imm, 5'd1, 3'b110, 5'd12, OPC_I));
        put(i_type(imm, 5'd1, 3'b111, 5'd13, OPC_I));
        put(i_type(imm, 5'd1, 3'b010, 5'd14, OPC_I)); // SLTI
        put(i_type(imm, 5'd1, 3'b011, 5'd15, OPC_I)); // SLTIU
        put(i_type({7'h00, sh}, 5'd1, 3'b001, 5'd16, OPC_I));
        put(i_type({7'h00, sh}, 5'd1, 3'b101, 5'd17, OPC_I));
        put(i_type({7'h20, sh}, 5'd1, 3'b101, 5'd18, OPC_I)); // SRAI
        put(i_type(12'h7ff, 5'd1, 3'b010, 5'd19, OPC_I));
        put(i_type(12'hfff, 5'd2, 3'b011, 5'd20, OPC_I)); // Against all ones
        put(u_type(up, 5'd21, OPC_LUI));
        auipc_pc = 32'(prog.size()) * 32'd4;
        put(u_type(up, 5'd22, OPC_AUIPC));
        expect_reg(5'd10, a + sx);
        expect_reg(5'd11, a ^ sx);
        expect_reg(5'd12, a | sx);
        expect_reg(5'd13, a & sx);
        expect_reg(5'd14, {31'b0, signed_less(a, sx)});
        expect_reg(5'd15, {31'b0, a < sx});
        expect_reg(5'd16, a << sh);
        expect_reg(5'd17, a >> sh);
        expect_reg(5'd18, (a >> sh) | ~(32'hffff_ffff >> sh));
        expect_reg(5'd19, {31'b0, signed_less(a, 32'h0000_07ff)});
        expect_reg(5'd20, {31'b0, b < 32'hffff_ffff});
        expect_reg(5'd21, {up, 12'b0});
        expect_reg(5'd22, auipc_pc + {up, 12'b0});
        run_program("i_type");
    endtask

    task automatic branch_outcomes();
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  f3s [6];
        logic [4:0]  ra [12];
        logic [4:0]  rb [12];
        logic        taken;
        a   = $urandom() | 32'h8000_0000;
        b   = $urandom() & 32'h7fff_ffff;
        f3s = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        // One taken and one not taken pair per branch
        ra  = '{5'd1, 5'd1, 5'd1, 5'd1, 5'd1, 5'd2, 5'd2, 5'd1, 5'd2, 5'd1, 5'd1, 5'd2};
        rb  = '{5'd1, 5'd2, 5'd2, 5'd1, 5'd2, 5'd1, 5'd1, 5'd2, 5'd1, 5'd2, 5'd2, 5'd1};
        new_program();
        load_const(5'd1, a);
        load_const(5'd2, b);
        for (int k = 0; k < 12; k++) begin
            put(b_type(13'd8, rb[k], ra[k], f3s[k / 2]));
            put(i_type(12'd1, 5'd0, 3'b000, 5'(8 + 2 * k), OPC_I)); // Shadow
            put(i_type(12'd1, 5'd0, 3'b000, 5'(9 + 2 * k), OPC_I)); // Target
            taken = branch_taken(f3s[k / 2], (ra[k] == 5'd1) ? a : b, (rb[k] == 5'd1) ? a : b);
            expect_reg(5'(8 + 2 * k), taken ? 32'd0 : 32'd1);
            expect_reg(5'(9 + 2 * k), 32'd1);
        end
        run_program("branches");
    endtask

    task automatic jump_links();
        int pc_jal;
        int pc_jr;
        new_program();
        pc_jal = 4 * prog.size();
        put(j_type(21'd12, 5'd5));
        put(i_type(12'd1, 5'd0, 3'b000, 5'd6, OPC_I));
        put(i_type(12'd1, 5'd0, 3'b000, 5'd7, OPC_I));
        put(i_type(12'd1, 5'd0, 3'b000, 5'd11, OPC_I));
        put(j_type(21'd8, 5'd0)); // Link into x0
        put(i_type(12'd1, 5'd0, 3'b000, 5'd12, OPC_I));
        put(i_type(12'd1, 5'd0, 3'b000, 5'd13, OPC_I));
        pc_jr = 4 * (prog.size() + 3);
        put_spaced(i_type(12'(pc_jr + 8), 5'd0, 3'b000, 5'd8, OPC_I));
        put(i_type(12'd5, 5'd8, 3'b000, 5'd9, OPC_JALR)); // Odd sum
        put(i_type(12'd1, 5'd0, 3'b000, 5'd14, OPC_I));
        put(i_type(12'd1, 5'd0, 3'b000, 5'd15, OPC_I));
        put(u_type(20'd0, 5'd16, OPC_AUIPC)); // Target records its own PC
        expect_reg(5'd0, 32'd0);
        expect_reg(5'd5, 32'(pc_jal + 4));
        expect_reg(5'd6, 32'd0);
        expect_reg(5'd7, 32'd0);
        expect_reg(5'd11, 32'd1);
        expect_reg(5'd12, 32'd0);
        expect_reg(5'd13, 32'd1);
        expect_reg(5'd8, 32'(pc_jr + 8));
        expect_reg(5'd9, 32'(pc_jr + 4));
        expect_reg(5'd14, 32'd0);
        expect_reg(5'd15, 32'd0);
        expect_reg(5'd16, 32'(pc_jr + 12));
        run_program("jumps");
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        run        = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        dbg_addr   = '0;
        errors     = 0;
        checks     = 0;
        void'($urandom(68058));
        #1;
        regs_clear_after_reset();
        r_type_results();
        i_type_results();
        branch_outcomes();
        jump_links();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/rv_core.sv
`default_nettype none

module rv_core #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          run,
    input  logic                          imem_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0] imem_addr,
    input  logic [31:0]                   imem_wdata,
    input  logic [4:0]                    dbg_addr,
    output logic [31:0]                   dbg_data
);

    logic [31:0] f_instr;
    logic [31:0] f_pc;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] d_instr;
    logic [31:0] d_pc;
    logic [31:0] d_op_a;
    logic [31:0] d_op_b;
    logic [31:0] d_imm;
    logic [3:0]  d_alu_op;
    logic [31:0] e_instr;
    logic [31:0] e_result;
    logic [31:0] e_target;
    logic        wb_we;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        redirect;
    logic [31:0] redirect_pc;

    rv_fetch #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) i_fetch (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_wdata  (imem_wdata),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .f_instr     (f_instr),
        .f_pc        (f_pc)
    );

    rv_decode i_decode (
        .clk      (clk),
        .rst      (rst),
        .f_instr  (f_instr),
        .f_pc     (f_pc),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .d_instr  (d_instr),
        .d_pc     (d_pc),
        .d_op_a   (d_op_a),
        .d_op_b   (d_op_b),
        .d_imm    (d_imm),
        .d_alu_op (d_alu_op)
    );

    rv_execute i_execute (
        .clk      (clk),
        .rst      (rst),
        .d_instr  (d_instr),
        .d_pc     (d_pc),
        .d_op_a   (d_op_a),
        .d_op_b   (d_op_b),
        .d_imm    (d_imm),
        .d_alu_op (d_alu_op),
        .e_instr  (e_instr),
        .e_result (e_result),
        .e_target (e_target)
    );

    rv_retire i_retire (
        .clk         (clk),
        .rst         (rst),
        .e_instr     (e_instr),
        .e_result    (e_result),
        .e_target    (e_target),
        .wb_we       (wb_we),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    rv_regfile i_regfile (
        .clk      (clk),
        .rst      (rst),
        .wb_we    (wb_we),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .dbg_addr (dbg_addr),
        .dbg_data (dbg_data)
    );

endmodule

`default_nettype wire

// File: src/rv_retire.sv
`default_nettype none

module rv_retire
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  instr_t   e_instr,
    input  word_t    e_result,
    input  word_t    e_target,
    output logic     wb_we,
    output reg_idx_t wb_addr,
    output word_t    wb_data,
    output logic     redirect,
    output word_t    redirect_pc
);

    logic writes_rd;
    logic is_ctrl;

    assign writes_rd = e_instr.r.opcode inside {OP_R, OP_I, OP_LUI, OP_AUIPC, OP_JAL, OP_JALR};
    assign is_ctrl   = e_instr.r.opcode inside {OP_BRANCH, OP_JAL, OP_JALR};

    // Memory slot register, drives the regfile write and redirect on the next edge
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_we    <= 1'b0;
            redirect <= 1'b0;
        end else begin
            wb_we    <= writes_rd;
            redirect <= is_ctrl; // One cycle, bubbles follow
        end
    end

    always_ff @(posedge clk) begin
        wb_addr     <= e_instr.r.rd;
        wb_data     <= e_result;
        redirect_pc <= e_target;
    end

endmodule

`default_nettype wire

// File: src/rv_execute.sv
`default_nettype none

module rv_execute
    import rv_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  instr_t     d_instr,
    input  word_t      d_pc,
    input  word_t      d_op_a,
    input  word_t      d_op_b,
    input  word_t      d_imm,
    input  logic [3:0] d_alu_op,
    output instr_t     e_instr,
    output word_t      e_result,
    output word_t      e_target
);

    alu_op_e    alu_op;
    logic [4:0] shamt;
    word_t      alu_out;
    word_t      pc_plus4;
    word_t      pc_imm;
    word_t      jalr_sum;
    word_t      result;
    word_t      target;
    logic       taken;

    assign alu_op   = alu_op_e'(d_alu_op);
    assign shamt    = d_op_b[4:0];
    assign pc_plus4 = d_pc + 32'd4;
    assign pc_imm   = d_pc + d_imm;
    assign jalr_sum = d_op_a + d_imm;

    always_comb begin
        case (alu_op)
            ALU_ADD:    alu_out = d_op_a + d_op_b;
            ALU_SUB:    alu_out = d_op_a - d_op_b;
            ALU_XOR:    alu_out = d_op_a ^ d_op_b;
            ALU_OR:     alu_out = d_op_a | d_op_b;
            ALU_AND:    alu_out = d_op_a & d_op_b;
            ALU_SLL:    alu_out = d_op_a << shamt;
            ALU_SRL:    alu_out = d_op_a >> shamt;
            ALU_SRA:    alu_out = $signed(d_op_a) >>> shamt;
            ALU_SLT:    alu_out = {31'b0, $signed(d_op_a) < $signed(d_op_b)};
            ALU_SLTU:   alu_out = {31'b0, d_op_a < d_op_b};
            ALU_PASS_B: alu_out = d_op_b; // LUI
            default:    alu_out = '0;
        endcase
    end

    always_comb begin
        case (d_instr.r.funct3)
            F3_BEQ:  taken = (d_op_a == d_op_b);
            F3_BNE:  taken = (d_op_a != d_op_b);
            F3_BLT:  taken = ($signed(d_op_a) < $signed(d_op_b));
            F3_BGE:  taken = ($signed(d_op_a) >= $signed(d_op_b));
            F3_BLTU: taken = (d_op_a < d_op_b);
            F3_BGEU: taken = (d_op_a >= d_op_b);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        result = alu_out;
        target = pc_plus4; // Fall through
        case (d_instr.r.opcode)
            OP_AUIPC: begin
                result = pc_imm;
            end
            OP_JAL: begin
                result = pc_plus4;
                target = pc_imm;
            end
            OP_JALR: begin
                result = pc_plus4;
                target = {jalr_sum[31:1], 1'b0};
            end
            OP_BRANCH: begin
                if (taken) begin
                    target = pc_imm;
                end
            end
            default: begin
                result = alu_out;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            e_instr <= NOP_INSTR;
        end else begin
            e_instr <= d_instr;
        end
    end

    always_ff @(posedge clk) begin
        e_result <= result;
        e_target <= target;
    end

endmodule

`default_nettype wire

// File: src/rv_decode.sv
`default_nettype none

module rv_decode
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  word_t    f_instr,
    input  word_t    f_pc,
    output reg_idx_t rs1_addr,
    output reg_idx_t rs2_addr,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    output instr_t   d_instr,
    output word_t    d_pc,
    output word_t    d_op_a,
    output word_t    d_op_b,
    output word_t    d_imm,
    output alu_op_e  d_alu_op
);

    instr_t  fi;
    word_t   imm;
    alu_op_e alu_op;
    logic    use_imm;
    logic    sub_sel;
    logic    sra_sel;

    assign fi       = f_instr;
    assign rs1_addr = fi.r.rs1;
    assign rs2_addr = fi.r.rs2;
    assign use_imm  = (fi.i.opcode == OP_I) || (fi.i.opcode == OP_LUI);

    always_comb begin
        case (fi.r.opcode)
            OP_LUI, OP_AUIPC: imm = {f_instr[31:12], 12'b0};
            OP_BRANCH: imm = {{20{f_instr[31]}}, f_instr[7], f_instr[30:25], f_instr[11:8], 1'b0};
            OP_JAL: imm = {{12{f_instr[31]}}, f_instr[19:12], f_instr[20], f_instr[30:21], 1'b0};
            default: imm = {{20{fi.i.imm12[11]}}, fi.i.imm12}; // I format and JALR
        endcase
    end

    // ADDI has no SUB form, SRAI keeps its flag in the immediate
    assign sub_sel = (fi.r.opcode == OP_R) && (fi.r.funct7 == F7_ALT);
    assign sra_sel = (fi.r.opcode == OP_R) ? (fi.r.funct7 == F7_ALT)
                                           : (fi.i.imm12[11:5] == F7_ALT);

    always_comb begin
        alu_op = ALU_ADD;
        if (fi.r.opcode == OP_LUI) begin
            alu_op = ALU_PASS_B;
        end else if (fi.r.opcode == OP_R || fi.r.opcode == OP_I) begin
            case (fi.r.funct3)
                F3_ADD:  alu_op = sub_sel ? ALU_SUB : ALU_ADD;
                F3_SLL:  alu_op = ALU_SLL;
                F3_SLT:  alu_op = ALU_SLT;
                F3_SLTU: alu_op = ALU_SLTU;
                F3_XOR:  alu_op = ALU_XOR;
                F3_SR:   alu_op = sra_sel ? ALU_SRA : ALU_SRL;
                F3_OR:   alu_op = ALU_OR;
                F3_AND:  alu_op = ALU_AND;
                default: alu_op = ALU_ADD;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            d_instr <= NOP_INSTR;
        end else begin
            d_instr <= fi;
        end
    end

    always_ff @(posedge clk) begin
        d_pc     <= f_pc;
        d_op_a   <= rs1_data;
        d_op_b   <= use_imm ? imm : rs2_data;
        d_imm    <= imm;
        d_alu_op <= alu_op;
    end

endmodule

`default_nettype wire

// File: src/rv_fetch.sv
`default_nettype none

module rv_fetch
    import rv_pkg::*;
#(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          run,
    input  logic                          imem_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0] imem_addr,
    input  word_t                         imem_wdata,
    input  logic                          redirect,
    input  word_t                         redirect_pc,
    output word_t                         f_instr,
    output word_t                         f_pc
);

    localparam int IMEM_AW = $clog2(IMEM_DEPTH);

    word_t imem [IMEM_DEPTH];
    word_t pc;
    word_t rd_word;
    logic  pending; // Branch or jump still in flight
    logic  is_ctrl;

    // Program load only while stopped
    always_ff @(posedge clk) begin
        if (imem_we && !run) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    assign rd_word = imem[pc[IMEM_AW+1:2]]; // Upper PC bits wrap
    assign is_ctrl = rd_word[6:0] inside {OP_BRANCH, OP_JAL, OP_JALR};

    always_ff @(posedge clk) begin
        if (rst || !run) begin
            pc      <= '0;
            pending <= 1'b0;
            f_instr <= NOP_INSTR;
        end else if (redirect) begin
            pc      <= redirect_pc;
            pending <= 1'b0;
            f_instr <= NOP_INSTR; // Fourth bubble
        end else if (pending) begin
            f_instr <= NOP_INSTR;
        end else begin
            pc      <= pc + 32'd4;
            pending <= is_ctrl;
            f_instr <= rd_word;
        end
    end

    always_ff @(posedge clk) begin
        f_pc <= pc;
    end

endmodule

`default_nettype wire

// File: src/rv_regfile.sv
`default_nettype none

module rv_regfile
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     wb_we,
    input  reg_idx_t wb_addr,
    input  word_t    wb_data,
    input  reg_idx_t rs1_addr,
    input  reg_idx_t rs2_addr,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  reg_idx_t dbg_addr,
    output word_t    dbg_data
);

    localparam int NREGS = 2 ** REG_AW;

    word_t regs [NREGS];
    logic  wr_en;

    assign wr_en = wb_we && (wb_addr != '0); // x0 stays zero

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < NREGS; k++) begin
                regs[k] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // Write-through so a reader two slots behind sees the value
    always_comb begin
        rs1_data = (wr_en && wb_addr == rs1_addr) ? wb_data : regs[rs1_addr];
        rs2_data = (wr_en && wb_addr == rs2_addr) ? wb_data : regs[rs2_addr];
    end

    assign dbg_data = regs[dbg_addr];

endmodule

`default_nettype wire

// File: src/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_AW-1:0] reg_idx_t;

    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_I      = 7'b0010011,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111
    } opcode_e;

    // ALU funct3, shared by register and immediate forms
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // SRL and SRA
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB, SRA, SRAI

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B
    } alu_op_e;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            reg_idx_t   rd;
            opcode_e    opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            reg_idx_t    rs1;
            logic [2:0]  funct3;
            reg_idx_t    rd;
            opcode_e     opcode;
        } i;
    } instr_t;

    localparam word_t NOP_INSTR = 32'h0000_0013; // ADDI x0, x0, 0

endpackage

`default_nettype wire
